// ==== vic_pkg.sv ====
package vic_pkg;

    // sprites overlaid on the graphics
    localparam int num_sprites = 8;

    // display mode packed as {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        standard_char      = 3'b000,
        multicolor_char    = 3'b001,
        standard_bitmap    = 3'b010,
        multicolor_bitmap  = 3'b011,
        extended_bg        = 3'b100,
        inv_ext_mc_char    = 3'b101,
        inv_ext_std_bitmap = 3'b110,
        inv_ext_mc_bitmap  = 3'b111
    } mode_t;

    // palette index
    typedef logic [3:0] color_t;

    localparam color_t color_black = 4'h0;

    // 12-bit word fetched with each cell, read differently in text and bitmap modes
    typedef union packed {
        struct packed {
            color_t     color;    // top bit also flags a multicolour char
            logic [1:0] ebc_sel;  // extended background select
            logic [5:0] code;
        } text;
        struct packed {
            color_t color11;
            color_t fg;
            color_t bg;
        } bitmap;
    } char_word_u;

endpackage

// ==== dot_timing.sv ====
module dot_timing #(
    parameter int cycles_per_line = 63
) (
    input  logic       clk_dot4x,
    input  logic       rst,
    output logic       dot_rising_0_o,
    output logic       dot_rising_1_o,
    output logic       phi_phase_start_0_o,
    output logic       phi_phase_start_dav_o,
    output logic       phi_phase_start_xscroll_latch_o,
    output logic [2:0] xpos_mod_8_o,
    output logic [6:0] cycle_num_o
);

    logic [1:0] tick;
    logic       last_tick;
    logic       last_pixel;

    assign last_tick  = tick == 2'd3;
    assign last_pixel = xpos_mod_8_o == 3'd7;

    // four clk_dot4x ticks per pixel, eight pixels per cycle
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick         <= '0;
            xpos_mod_8_o <= '0;
            cycle_num_o  <= '0;
        end else begin
            tick <= tick + 2'd1;
            if (last_tick) begin
                xpos_mod_8_o <= xpos_mod_8_o + 3'd1;
                if (last_pixel) begin
                    if (cycle_num_o == 7'(cycles_per_line - 1)) begin
                        cycle_num_o <= '0;
                    end else begin
                        cycle_num_o <= cycle_num_o + 7'd1;
                    end
                end
            end
        end
    end

    // decoded one tick ahead so each pulse lines up with the counters
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_rising_0_o                  <= 1'b0;
            dot_rising_1_o                  <= 1'b0;
            phi_phase_start_0_o             <= 1'b0;
            phi_phase_start_dav_o           <= 1'b0;
            phi_phase_start_xscroll_latch_o <= 1'b0;
        end else begin
            dot_rising_0_o                  <= last_tick;
            dot_rising_1_o                  <= tick == 2'd0;
            phi_phase_start_0_o             <= last_tick && last_pixel;
            // tick 0 of pixel 4
            phi_phase_start_dav_o           <= last_tick && xpos_mod_8_o == 3'd3;
            // tick 2 of pixel 7
            phi_phase_start_xscroll_latch_o <= tick == 2'd1 && last_pixel;
        end
    end

endmodule

// ==== graphics_shifter.sv ====
module graphics_shifter import vic_pkg::*; (
    input  logic       clk_dot4x,
    input  logic       rst,
    input  logic       dot_rising_0_i,
    input  logic       dot_rising_1_i,
    input  logic       phi_phase_start_0_i,
    input  logic       phi_phase_start_dav_i,
    input  logic       phi_phase_start_xscroll_latch_i,
    input  logic [2:0] xpos_mod_8_i,
    input  logic [6:0] cycle_num_i,
    input  logic [2:0] xscroll_i,
    input  mode_t      mode_i,
    input  logic [7:0] pixels_read_i,
    input  char_word_u char_read_i,
    output logic [1:0] pixel_bits_o,
    output char_word_u char_word_o,
    output logic       bg_pixel_o,
    output logic       stage0_o
);

    logic [2:0] xscroll_latched;
    logic [7:0] pixels_dly0;
    logic [7:0] pixels_dly1;
    logic [7:0] pixels_load;
    logic [7:0] pixels_shift;
    char_word_u char_dly0;
    char_word_u char_dly1;
    char_word_u char_load;
    char_word_u char_shift;
    logic       ecm;
    logic       bmm;
    logic       mcm;
    logic       is_mc;
    logic       load_pixels;
    logic       shift_en;

    assign {ecm, bmm, mcm} = mode_i;

    // multicolour for the cell being shifted
    assign is_mc = mcm & (bmm | ecm | char_shift.text.color[3]);

    assign load_pixels = xpos_mod_8_i == xscroll_latched;

    // fetched data waits two dav slots and sits ready from pixel 0
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xscroll_latched <= '0;
            pixels_dly0     <= '0;
            pixels_dly1     <= '0;
            pixels_load     <= '0;
            char_dly0       <= '0;
            char_dly1       <= '0;
            char_load       <= '0;
        end else begin
            // only visible cycles move the scroll
            if (phi_phase_start_xscroll_latch_i && cycle_num_i >= 7'd15 &&
                cycle_num_i <= 7'd55) begin
                xscroll_latched <= xscroll_i;
            end
            if (phi_phase_start_dav_i) begin
                pixels_dly0 <= pixels_read_i;
                pixels_dly1 <= pixels_dly0;
                char_dly0   <= char_read_i;
                char_dly1   <= char_dly0;
            end
            if (phi_phase_start_0_i) begin
                pixels_load <= pixels_dly1;
                char_load   <= char_dly1;
            end
        end
    end

    // multicolour pairs hold for two dots
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_en <= 1'b0;
        end else if (dot_rising_0_i) begin
            if (load_pixels) begin
                shift_en <= 1'b1;
            end else if (is_mc) begin
                shift_en <= ~shift_en;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            stage0_o     <= 1'b0;
            pixels_shift <= '0;
            char_shift   <= '0;
            bg_pixel_o   <= 1'b1;
        end else begin
            stage0_o <= dot_rising_1_i;
            if (dot_rising_1_i) begin
                if (load_pixels) begin
                    pixels_shift <= pixels_load;
                    char_shift   <= char_load;
                    bg_pixel_o   <= ~pixels_load[7];
                end else if (shift_en) begin
                    if (is_mc) begin
                        pixels_shift <= {pixels_shift[5:0], 2'b00};
                        bg_pixel_o   <= ~pixels_shift[5];
                    end else begin
                        pixels_shift <= {pixels_shift[6:0], 1'b0};
                        bg_pixel_o   <= ~pixels_shift[6];
                    end
                end
            end
        end
    end

    assign pixel_bits_o = pixels_shift[7:6];
    assign char_word_o  = char_shift;

endmodule

// ==== mode_color.sv ====
module mode_color import vic_pkg::*; (
    input  logic       clk_dot4x,
    input  logic       rst,
    input  logic       stage0_i,
    input  mode_t      mode_i,
    input  logic [1:0] pixel_bits_i,
    input  char_word_u char_word_i,
    input  logic       bg_pixel_i,
    input  color_t     b0c_i,
    input  color_t     b1c_i,
    input  color_t     b2c_i,
    input  color_t     b3c_i,
    input  logic       main_border_i,
    output color_t     colour1_o,
    output logic       bg1_o,
    output logic       border1_o,
    output logic       stage1_o
);

    color_t colour_next;
    color_t hires_char;
    color_t ext_bg;

    // single-bit text pixel
    assign hires_char = pixel_bits_i[1] ? char_word_i.text.color : b0c_i;

    always_comb begin
        case ({pixel_bits_i[1], char_word_i.text.ebc_sel})
            3'b000:  ext_bg = b0c_i;
            3'b001:  ext_bg = b1c_i;
            3'b010:  ext_bg = b2c_i;
            3'b011:  ext_bg = b3c_i;
            default: ext_bg = char_word_i.text.color;
        endcase
    end

    always_comb begin
        colour_next = color_black;
        case (mode_i)
            standard_char: colour_next = hires_char;
            multicolor_char: begin
                if (char_word_i.text.color[3]) begin
                    case (pixel_bits_i)
                        2'b00: colour_next = b0c_i;
                        2'b01: colour_next = b1c_i;
                        2'b10: colour_next = b2c_i;
                        2'b11: colour_next = {1'b0, char_word_i.text.color[2:0]};
                    endcase
                end else begin
                    colour_next = hires_char;
                end
            end
            // illegal bitmap variants decode the same, they get blanked later
            standard_bitmap, inv_ext_std_bitmap: begin
                colour_next = pixel_bits_i[1] ? char_word_i.bitmap.fg : char_word_i.bitmap.bg;
            end
            multicolor_bitmap, inv_ext_mc_bitmap: begin
                case (pixel_bits_i)
                    2'b00: colour_next = b0c_i;
                    2'b01: colour_next = char_word_i.bitmap.fg;
                    2'b10: colour_next = char_word_i.bitmap.bg;
                    2'b11: colour_next = char_word_i.bitmap.color11;
                endcase
            end
            extended_bg: colour_next = ext_bg;
            default: colour_next = color_black;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            colour1_o <= color_black;
            bg1_o     <= 1'b1;
            border1_o <= 1'b0;
            stage1_o  <= 1'b0;
        end else begin
            stage1_o <= stage0_i;
            if (stage0_i) begin
                colour1_o <= colour_next;
                bg1_o     <= bg_pixel_i;
                border1_o <= main_border_i;
            end
        end
    end

endmodule

// ==== sprite_border_mixer.sv ====
module sprite_border_mixer import vic_pkg::*; (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     stage1_i,
    input  logic                     dot_rising_1_i,
    input  mode_t                    mode_i,
    input  color_t                   colour1_i,
    input  logic                     bg1_i,
    input  logic                     border1_i,
    input  logic [2*num_sprites-1:0] sprite_pixel_i,
    input  logic [num_sprites-1:0]   sprite_pri_i,
    input  logic [num_sprites-1:0]   sprite_mmc_i,
    input  logic [4*num_sprites-1:0] sprite_col_i,
    input  color_t                   sprite_mc0_i,
    input  color_t                   sprite_mc1_i,
    input  color_t                   ec_i,
    output color_t                   pixel_color_o
);

    logic       illegal;
    logic [1:0] pair;
    color_t     base;
    color_t     mixed;
    color_t     colour2;
    color_t     colour2a;
    color_t     colour2b;
    color_t     colour2c;
    logic       border2;
    logic       border2a;
    logic       border2b;
    logic       border2c;

    assign illegal = (mode_i == inv_ext_mc_char) || (mode_i == inv_ext_std_bitmap) ||
                     (mode_i == inv_ext_mc_bitmap);
    assign base    = illegal ? color_black : colour1_i;

    // walk down so sprite 0 is applied last and wins
    always_comb begin
        mixed = base;
        pair  = 2'b00;
        for (int n = num_sprites - 1; n >= 0; n--) begin
            pair = sprite_pixel_i[2*n +: 2];
            if (!sprite_pri_i[n] || bg1_i) begin
                if (sprite_mmc_i[n]) begin
                    case (pair)
                        2'b01:   mixed = sprite_mc0_i;
                        2'b10:   mixed = sprite_col_i[4*n +: 4];
                        2'b11:   mixed = sprite_mc1_i;
                        default: mixed = mixed;
                    endcase
                end else if (pair[1]) begin
                    mixed = sprite_col_i[4*n +: 4];
                end
            end
            // a higher sprite sitting behind foreground undoes a lower one
            if (sprite_pri_i[n] && !bg1_i && pair[1]) begin
                mixed = base;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            colour2  <= color_black;
            border2  <= 1'b0;
            colour2a <= color_black;
            colour2b <= color_black;
            colour2c <= color_black;
            border2a <= 1'b0;
            border2b <= 1'b0;
            border2c <= 1'b0;
        end else begin
            if (stage1_i) begin
                colour2 <= mixed;
                border2 <= border1_i;
            end
            // three more pixels to line up with the border edge
            if (dot_rising_1_i) begin
                colour2a <= colour2;
                colour2b <= colour2a;
                colour2c <= colour2b;
                border2a <= border2;
                border2b <= border2a;
                border2c <= border2b;
            end
        end
    end

    // border mask
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color_o <= color_black;
        end else begin
            pixel_color_o <= border2c ? ec_i : colour2c;
        end
    end

endmodule

// ==== vic_video_top.sv ====
module vic_video_top import vic_pkg::*; #(
    parameter int cycles_per_line = 63
) (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  mode_t                    mode_i,
    input  logic [2:0]               xscroll_i,
    input  logic [7:0]               pixels_read_i,
    input  char_word_u               char_read_i,
    input  color_t                   b0c_i,
    input  color_t                   b1c_i,
    input  color_t                   b2c_i,
    input  color_t                   b3c_i,
    input  color_t                   ec_i,
    input  logic                     main_border_i,
    input  logic [2*num_sprites-1:0] sprite_pixel_i,
    input  logic [num_sprites-1:0]   sprite_pri_i,
    input  logic [num_sprites-1:0]   sprite_mmc_i,
    input  logic [4*num_sprites-1:0] sprite_col_i,
    input  color_t                   sprite_mc0_i,
    input  color_t                   sprite_mc1_i,
    output color_t                   pixel_color_o,
    output logic                     dav_o
);

    logic       dot_rising_0;
    logic       dot_rising_1;
    logic       phi_start_0;
    logic       phi_start_dav;
    logic       phi_start_xscroll;
    logic [2:0] xpos_mod_8;
    logic [6:0] cycle_num;
    logic [1:0] pixel_bits;
    char_word_u char_word;
    logic       bg_pixel;
    logic       stage0;
    color_t     colour1;
    logic       bg1;
    logic       border1;
    logic       stage1;

    // the source presents the next fetch on this pulse
    assign dav_o = phi_start_dav;

    dot_timing #(
        .cycles_per_line(cycles_per_line)
    ) dot_timing_inst (
        .clk_dot4x                      (clk_dot4x),
        .rst                            (rst),
        .dot_rising_0_o                 (dot_rising_0),
        .dot_rising_1_o                 (dot_rising_1),
        .phi_phase_start_0_o            (phi_start_0),
        .phi_phase_start_dav_o          (phi_start_dav),
        .phi_phase_start_xscroll_latch_o(phi_start_xscroll),
        .xpos_mod_8_o                   (xpos_mod_8),
        .cycle_num_o                    (cycle_num)
    );

    graphics_shifter graphics_shifter_inst (
        .clk_dot4x                      (clk_dot4x),
        .rst                            (rst),
        .dot_rising_0_i                 (dot_rising_0),
        .dot_rising_1_i                 (dot_rising_1),
        .phi_phase_start_0_i            (phi_start_0),
        .phi_phase_start_dav_i          (phi_start_dav),
        .phi_phase_start_xscroll_latch_i(phi_start_xscroll),
        .xpos_mod_8_i                   (xpos_mod_8),
        .cycle_num_i                    (cycle_num),
        .xscroll_i                      (xscroll_i),
        .mode_i                         (mode_i),
        .pixels_read_i                  (pixels_read_i),
        .char_read_i                    (char_read_i),
        .pixel_bits_o                   (pixel_bits),
        .char_word_o                    (char_word),
        .bg_pixel_o                     (bg_pixel),
        .stage0_o                       (stage0)
    );

    mode_color mode_color_inst (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .stage0_i     (stage0),
        .mode_i       (mode_i),
        .pixel_bits_i (pixel_bits),
        .char_word_i  (char_word),
        .bg_pixel_i   (bg_pixel),
        .b0c_i        (b0c_i),
        .b1c_i        (b1c_i),
        .b2c_i        (b2c_i),
        .b3c_i        (b3c_i),
        .main_border_i(main_border_i),
        .colour1_o    (colour1),
        .bg1_o        (bg1),
        .border1_o    (border1),
        .stage1_o     (stage1)
    );

    sprite_border_mixer sprite_border_mixer_inst (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .stage1_i      (stage1),
        .dot_rising_1_i(dot_rising_1),
        .mode_i        (mode_i),
        .colour1_i     (colour1),
        .bg1_i         (bg1),
        .border1_i     (border1),
        .sprite_pixel_i(sprite_pixel_i),
        .sprite_pri_i  (sprite_pri_i),
        .sprite_mmc_i  (sprite_mmc_i),
        .sprite_col_i  (sprite_col_i),
        .sprite_mc0_i  (sprite_mc0_i),
        .sprite_mc1_i  (sprite_mc1_i),
        .ec_i          (ec_i),
        .pixel_color_o (pixel_color_o)
    );

endmodule

// ==== tb_vic_model.svh ====
`ifndef TB_VIC_MODEL_SVH
`define TB_VIC_MODEL_SVH

// cells shifted out as bit pairs
function automatic logic is_multicolor(mode_t mode_v, char_word_u word);
    case (mode_v)
        multicolor_char: return word.text.color[3];
        multicolor_bitmap, inv_ext_mc_char, inv_ext_mc_bitmap: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// bit pair seen at offset k after the load
// multicolour pairs hold for two pixels each
function automatic logic [1:0] shifted_bits(logic [7:0] data, int k, logic mc);
    int idx;
    if (!mc) begin
        return {data[7-k], 1'b0};
    end
    idx = k / 2;
    return {data[7-2*idx], data[6-2*idx]};
endfunction

function automatic color_t decode_mode_color(mode_t mode_v, logic [1:0] bits, char_word_u word,
                                             color_t c0, color_t c1, color_t c2, color_t c3);
    color_t hires;
    hires = bits[1] ? word.text.color : c0;
    case (mode_v)
        standard_char: return hires;
        multicolor_char: begin
            if (!word.text.color[3]) begin
                return hires;
            end
            case (bits)
                2'b00:   return c0;
                2'b01:   return c1;
                2'b10:   return c2;
                default: return {1'b0, word.text.color[2:0]};
            endcase
        end
        standard_bitmap: return bits[1] ? word.bitmap.fg : word.bitmap.bg;
        multicolor_bitmap: begin
            case (bits)
                2'b00:   return c0;
                2'b01:   return word.bitmap.fg;
                2'b10:   return word.bitmap.bg;
                default: return word.bitmap.color11;
            endcase
        end
        extended_bg: begin
            if (bits[1]) begin
                return word.text.color;
            end
            case (word.text.ebc_sel)
                2'b00:   return c0;
                2'b01:   return c1;
                2'b10:   return c2;
                default: return c3;
            endcase
        end
        default: return color_black;
    endcase
endfunction

// sprite 7 applied first and sprite 0 last
function automatic color_t overlay_sprites(color_t base, logic bg, logic [15:0] pix,
                                           logic [7:0] pri, logic [7:0] mmc, logic [31:0] col,
                                           color_t mc0, color_t mc1);
    color_t result;
    logic [1:0] pair;
    result = base;
    for (int n = 7; n >= 0; n--) begin
        pair = pix[2*n +: 2];
        if (!pri[n] || bg) begin
            if (mmc[n]) begin
                if (pair == 2'b01) result = mc0;
                if (pair == 2'b10) result = col[4*n +: 4];
                if (pair == 2'b11) result = mc1;
            end else if (pair[1]) begin
                result = col[4*n +: 4];
            end
        end else if (pair[1]) begin
            // graphics colour comes back behind the foreground
            result = base;
        end
    end
    return result;
endfunction

`endif

// ==== tb_vic_video.sv ====
module tb_vic_video import vic_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cycles_per_line = 63;

    logic        clk_dot4x;
    logic        rst;
    mode_t       mode;
    logic [2:0]  xscroll;
    logic [7:0]  pixels_read;
    char_word_u  char_read;
    color_t      b0c;
    color_t      b1c;
    color_t      b2c;
    color_t      b3c;
    color_t      ec;
    logic        main_border;
    logic [15:0] sprite_pixel;
    logic [7:0]  sprite_pri;
    logic [7:0]  sprite_mmc;
    logic [31:0] sprite_col;
    color_t      sprite_mc0;
    color_t      sprite_mc1;
    color_t      pixel_color;
    logic        dav;

    logic [31:0] rng_state = 32'd81435;
    int          clk_count;
    int          in_change_k;
    int          xs_change_k;
    logic [2:0]  model_xs;
    int          mismatches;
    int          timeouts;
    int          pix;

    `include "tb_vic_model.svh"

    vic_video_top #(
        .cycles_per_line(cycles_per_line)
    ) vic_video_top_inst (
        .clk_dot4x(clk_dot4x), .rst(rst), .mode_i(mode), .xscroll_i(xscroll),
        .pixels_read_i(pixels_read), .char_read_i(char_read),
        .b0c_i(b0c), .b1c_i(b1c), .b2c_i(b2c), .b3c_i(b3c), .ec_i(ec),
        .main_border_i(main_border), .sprite_pixel_i(sprite_pixel),
        .sprite_pri_i(sprite_pri), .sprite_mmc_i(sprite_mmc), .sprite_col_i(sprite_col),
        .sprite_mc0_i(sprite_mc0), .sprite_mc1_i(sprite_mc1),
        .pixel_color_o(pixel_color), .dav_o(dav)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #20 clk_dot4x = ~clk_dot4x;
    end

    function automatic logic [15:0] rand16();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    task automatic compare_color(input string name, input color_t expected, input color_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_pulse(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0d ns: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // colour for offset k within the current cell once inputs settle
    function automatic color_t expected_pixel(int k);
        logic       mc;
        logic [1:0] bits;
        color_t     base;
        mc   = is_multicolor(mode, char_read);
        bits = shifted_bits(pixels_read, k, mc);
        base = decode_mode_color(mode, bits, char_read, b0c, b1c, b2c, b3c);
        if (main_border) begin
            return ec;
        end
        return overlay_sprites(base, !bits[1], sprite_pixel, sprite_pri, sprite_mmc,
                               sprite_col, sprite_mc0, sprite_mc1);
    endfunction

    // clock count and the scroll value the DUT latches in visible cycles
    always @(posedge clk_dot4x) begin
        if (rst) begin
            clk_count <= 0;
            model_xs  <= 3'd0;
        end else begin
            clk_count <= clk_count + 1;
            if (clk_count % 32 == 30 && (clk_count / 32) % cycles_per_line >= 15 &&
                (clk_count / 32) % cycles_per_line <= 55 && model_xs != xscroll) begin
                model_xs    <= xscroll;
                xs_change_k <= clk_count + 1;
            end
        end
    end

    // pixel pix sits on the output 16 clocks after its dot starts
    always @(negedge clk_dot4x) begin
        if (!rst) begin
            compare_pulse("dav_o", clk_count % 32 == 16, dav);
            if (clk_count >= 16 && clk_count % 4 == 0) begin
                pix = clk_count / 4 - 4;
                if (in_change_k + 224 <= 4 * pix && xs_change_k + 64 <= 4 * pix + 2) begin
                    compare_color("pixel_color_o", expected_pixel((pix - model_xs + 8) % 8),
                                  pixel_color);
                end
            end
        end
    end

    task automatic wait_dav_pulses(input int count);
        int  waited;
        logic found;
        for (int i = 0; i < count && timeouts == 0; i++) begin
            waited = 0;
            found  = 1'b0;
            while (!found && waited < 200) begin
                @(negedge clk_dot4x);
                waited++;
                found = dav;
            end
            if (!found) begin
                timeouts++;
                $display("No dav pulse seen within 200 cycles at %0d ns", $time);
            end
        end
    endtask

    // kind 0 border, 1 text, 2 bitmap, 3 illegal, 4 sprites, 5 scroll only
    task automatic drive_segment(input int kind);
        logic [15:0] r;
        r = rand16();
        xscroll <= r[2:0];
        if (kind != 5) begin
            in_change_k = clk_count;
            case (kind)
                0: mode <= mode_t'(r[5:3]);
                1: mode <= (r[4:3] == 2'd0) ? extended_bg : mode_t'({2'b00, r[3]});
                2: mode <= mode_t'({2'b01, r[3]});
                3: mode <= (r[4:3] == 2'd0) ? inv_ext_mc_char : mode_t'({2'b11, r[3]});
                default: mode <= mode_t'(r[3] ? {2'b00, r[4]} : {2'b01, r[5]});
            endcase
            main_border  <= kind == 0;
            pixels_read  <= r[15:8];
            r = rand16();
            char_read    <= r[11:0];
            ec           <= r[15:12];
            r = rand16();
            {b0c, b1c, b2c, b3c} <= r;
            r = rand16();
            sprite_pixel <= (kind == 0 || kind == 4) ? r : 16'h0000;
            r = rand16();
            {sprite_pri, sprite_mmc} <= r;
            sprite_col   <= {rand16(), rand16()};
            r = rand16();
            {sprite_mc0, sprite_mc1} <= r[7:0];
        end
    endtask

    initial begin
        rst          = 1'b1;
        mode         = standard_char;
        xscroll      = 3'd0;
        pixels_read  = 8'h00;
        char_read    = '0;
        {b0c, b1c, b2c, b3c, ec} = '0;
        main_border  = 1'b0;
        sprite_pixel = '0;
        sprite_pri   = '0;
        sprite_mmc   = '0;
        sprite_col   = '0;
        sprite_mc0   = color_black;
        sprite_mc1   = color_black;
        in_change_k  = 0;
        xs_change_k  = 0;
        mismatches   = 0;
        timeouts     = 0;
        repeat (16) @(posedge clk_dot4x);
        rst <= 1'b0;
        for (int seg = 0; seg < 72 && timeouts == 0; seg++) begin
            @(posedge clk_dot4x);
            drive_segment(seg % 6);
            wait_dav_pulses(12);
        end
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== vic_pixel.f ====
+incdir+.
vic_pkg.sv
dot_timing.sv
graphics_shifter.sv
mode_color.sv
sprite_border_mixer.sv
vic_video_top.sv
tb_vic_video.sv
